// File: filelist.f
+incdir+common
common/pool_pkg.sv
verilog/pipe_fifo.sv
verilog/block_throttle.sv
pool/window_gather.sv
pool/pool_3x3.sv
verilog/pool_top.sv
tb/pool_top_chk.sv
tb/tb_pool_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the pool_top testbench with Verilator and run it.
# The exit status is the simulator's, nonzero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_pool_top --Mdir obj_dir -f filelist.f \
	&& ./obj_dir/Vtb_pool_top \
	&& echo "Simulation run completed" \
	|| { echo "Simulation run failed"; exit 1; }

// File: tb/tb_pool_top.sv
`include "pool_cfg.svh"

module tb_pool_top;

	timeunit 1ns;
	timeprecision 1ps;

	import pool_pkg::*;

	localparam int NCASE = 14;
	localparam int NRAND = 40;
	localparam int NFLAG = 6;
	localparam int NBP = 40;
	localparam int BLOCK = `POOL_BLOCK_SIZE;
	localparam int TOTAL_WORDS = (NCASE + NRAND + NFLAG + NBP) * 9;
	localparam int MAX_CYCLES = 20 * TOTAL_WORDS;
	// Last write to pipe_out_ready, plus margin for the FIFOs and throttle
	localparam int SETTLE = `POOL_LATENCY + 8;
	// Full output FIFO worth of windows plus a full input FIFO
	localparam int STALL_WORD_LIMIT = `POOL_FIFO_DEPTH * 9 + `POOL_FIFO_DEPTH;

	logic okClk = 1'b0;
	logic arst_n;
	logic pi_write;
	pipe_word_t pi_data;
	logic pipe_in_ready;
	logic pipe_in_full;
	logic po_read;
	pool_elem_t po_data;
	logic pipe_out_ready;
	logic pipe_out_empty;

	pipe_word_t tx_q [$];  // Words waiting for the host pipe
	int exp_q [$];         // Expected maxima in order
	string name_q [$];
	logic wr_allow;
	logic rd_allow;
	logic [31:0] rng_state = 32'd43772;
	int cycle_count = 0;

	string case_name [NCASE];
	int case_elem [NCASE][9];
	int case_max [NCASE];

	always #4 okClk = ~okClk;

	pool_top i_dut (
		.okClk          (okClk),
		.arst_n         (arst_n),
		.pi_write       (pi_write),
		.pi_data        (pi_data),
		.pipe_in_ready  (pipe_in_ready),
		.pipe_in_full   (pipe_in_full),
		.po_read        (po_read),
		.po_data        (po_data),
		.pipe_out_ready (pipe_out_ready),
		.pipe_out_empty (pipe_out_empty)
	);

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		if (expected !== actual) begin
			fail_run($sformatf("[ERROR] %s expected %0d actual %0d", name, expected, actual));
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Reference model, largest signed element
	function automatic int window_max(input int elems [9]);
		int m;
		m = elems[0];
		for (int i = 1; i < 9; i++) begin
			if (elems[i] > m) begin
				m = elems[i];
			end
		end
		return m;
	endfunction

	task automatic queue_window(input string name, input int elems [9], input int expected);
		logic [15:0] noise;
		for (int i = 0; i < 9; i++) begin
			rng_state = xorshift32(rng_state);
			noise = rng_state[31:16];  // High half must be ignored
			tx_q.push_back({noise, 16'(elems[i])});
		end
		exp_q.push_back(expected);
		name_q.push_back(name);
	endtask

	task automatic random_window(output int elems [9]);
		for (int i = 0; i < 9; i++) begin
			rng_state = xorshift32(rng_state);
			elems[i] = int'($signed(rng_state[15:0]));
		end
	endtask

	// One cycle of host activity, driven on the falling edge
	task automatic step();
		@(negedge okClk);
		if (wr_allow && pipe_in_ready && tx_q.size() > 0) begin
			pi_write = 1'b1;
			pi_data = tx_q.pop_front();
		end else begin
			pi_write = 1'b0;
		end
		if (rd_allow && !pipe_out_empty) begin
			if (exp_q.size() == 0) begin
				fail_run("Output pipe holds a result that no window produced");
			end else begin
				check_value(name_q.pop_front(), exp_q.pop_front(), int'(po_data));
				po_read = 1'b1;
			end
		end else begin
			po_read = 1'b0;
		end
	endtask

	task automatic settle();
		repeat (SETTLE) step();
	endtask

	task automatic run_until_drained();
		while (exp_q.size() > 0 || tx_q.size() > 0) begin
			step();
		end
	endtask

	task automatic load_table();
		case_name[0] = "all_negative";
		case_elem[0] = '{-5, -3, -100, -7, -2, -9, -32768, -4, -6};
		case_max[0] = -2;
		case_name[1] = "mixed_signs";
		case_elem[1] = '{12, -40, 7, -1, 0, 33, -200, 5, -8};
		case_max[1] = 33;
		case_name[2] = "ties";
		case_elem[2] = '{9, -9, 9, 3, 9, 1, -20, 9, 0};
		case_max[2] = 9;
		case_name[3] = "all_equal";
		case_elem[3] = '{-7, -7, -7, -7, -7, -7, -7, -7, -7};
		case_max[3] = -7;
		case_name[4] = "full_range";
		case_elem[4] = '{-32768, 32767, -1, 0, 1, -32767, 32766, 100, -100};
		case_max[4] = 32767;
		// Maximum walks through all nine positions
		for (int k = 0; k < 9; k++) begin
			case_name[5+k] = $sformatf("max_at_%0d", k);
			for (int i = 0; i < 9; i++) begin
				case_elem[5+k][i] = -1000 + 37 * i;
			end
			case_elem[5+k][k] = 300 + k;
			case_max[5+k] = 300 + k;
		end
	endtask

	// --------------------------------------------------
	// Timeout
	// --------------------------------------------------
	always @(posedge okClk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > MAX_CYCLES) begin
			fail_run($sformatf("Timeout after %0d cycles, the DUT stopped moving data",
				cycle_count));
		end
	end

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial begin
		int elems [9];
		arst_n = 1'b0;
		pi_write = 1'b0;
		pi_data = '0;
		po_read = 1'b0;
		wr_allow = 1'b0;
		rd_allow = 1'b0;
		load_table();
		repeat (8) @(posedge okClk);
		@(negedge okClk);
		arst_n = 1'b1;

		step();  // Ready flag one cycle after release
		check_value("reset_out_empty", 1, int'(pipe_out_empty));
		check_value("reset_out_ready", 0, int'(pipe_out_ready));
		check_value("reset_in_ready", 1, int'(pipe_in_ready));

		// Table windows
		wr_allow = 1'b1;
		rd_allow = 1'b1;
		for (int c = 0; c < NCASE; c++) begin
			queue_window(case_name[c], case_elem[c], case_max[c]);
		end
		run_until_drained();

		// Random windows back to back
		for (int n = 0; n < NRAND; n++) begin
			random_window(elems);
			queue_window($sformatf("random_%0d", n), elems, window_max(elems));
		end
		run_until_drained();

		// pipe_out_ready while results pile up, then drain one by one
		rd_allow = 1'b0;
		for (int k = 1; k <= NFLAG; k++) begin
			random_window(elems);
			queue_window($sformatf("flag_%0d", k), elems, window_max(elems));
			while (tx_q.size() > 0) begin
				step();
			end
			settle();
			check_value($sformatf("out_ready_fill_%0d", k), int'(k >= BLOCK),
				int'(pipe_out_ready));
			check_value($sformatf("out_empty_fill_%0d", k), 0, int'(pipe_out_empty));
		end
		for (int k = NFLAG - 1; k >= 0; k--) begin
			rd_allow = 1'b1;
			step();
			rd_allow = 1'b0;
			settle();
			check_value($sformatf("out_ready_drain_%0d", k), int'(k >= BLOCK),
				int'(pipe_out_ready));
			check_value($sformatf("out_empty_drain_%0d", k), int'(k == 0),
				int'(pipe_out_empty));
		end

		// Back-pressure with the output left unread
		for (int n = 0; n < NBP; n++) begin
			random_window(elems);
			queue_window($sformatf("stall_%0d", n), elems, window_max(elems));
		end
		while (pipe_in_ready && tx_q.size() > 0) begin
			step();
		end
		if (tx_q.size() == 0) begin
			fail_run("Input pipe never throttled while the output stayed unread");
		end
		settle();
		check_value("stall_in_ready", 0, int'(pipe_in_ready));
		check_value("stall_in_full", 0, int'(pipe_in_full));
		check_value("stall_out_ready", 1, int'(pipe_out_ready));
		// Words taken beyond this would mean more results than the output FIFO holds
		check_value("stall_result_limit", 1,
			int'(NBP * 9 - tx_q.size() <= STALL_WORD_LIMIT));
		rd_allow = 1'b1;
		run_until_drained();
		settle();

		if (exp_q.size() == 0 && tx_q.size() == 0 && pipe_out_empty) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			fail_run("Results missing or left over at the end of the run");
		end
	end

endmodule

// File: tb/pool_top_chk.sv
`include "pool_cfg.svh"

module pool_top_chk (
	input logic okClk,
	input logic arst_n,
	input logic pi_write,
	input logic pipe_in_full,
	input logic po_read,
	input logic pipe_out_empty,
	input logic win_valid,
	input logic res_valid,
	input logic [`POOL_FIFO_CNT_W-1:0] out_count
);

	timeunit 1ns;
	timeprecision 1ps;

	// --------------------------------------------------
	// FIFO overflow and underflow
	// --------------------------------------------------
	a_in_no_overflow: assert property (@(posedge okClk) disable iff (!arst_n)
		pi_write |-> !pipe_in_full)
		else $error("Host wrote into a full input FIFO");

	a_out_no_overflow: assert property (@(posedge okClk) disable iff (!arst_n)
		res_valid |-> (int'(out_count) < `POOL_FIFO_DEPTH))
		else $error("Result written into a full output FIFO");

	a_out_no_underflow: assert property (@(posedge okClk) disable iff (!arst_n)
		po_read |-> !pipe_out_empty)
		else $error("Host read an empty output FIFO");

	// Fixed depth of the comparison tree
	a_latency: assert property (@(posedge okClk) disable iff (!arst_n)
		res_valid == $past(win_valid, `POOL_LATENCY))
		else $error("res_valid does not follow win_valid by the tree depth");

endmodule

bind pool_top pool_top_chk i_chk (
	.okClk          (okClk),
	.arst_n         (arst_n),
	.pi_write       (pi_write),
	.pipe_in_full   (pipe_in_full),
	.po_read        (po_read),
	.pipe_out_empty (pipe_out_empty),
	.win_valid      (win_valid),
	.res_valid      (res_valid),
	.out_count      (out_count)
);

// File: verilog/pool_top.sv
`include "pool_cfg.svh"

module pool_top (
	input  logic okClk,
	input  logic arst_n,
	input  logic pi_write,
	input  pool_pkg::pipe_word_t pi_data,
	output logic pipe_in_ready,
	output logic pipe_in_full,
	input  logic po_read,
	output pool_pkg::pool_elem_t po_data,
	output logic pipe_out_ready,
	output logic pipe_out_empty
);

	import pool_pkg::*;

	pipe_word_t in_data;
	logic in_empty;
	logic in_pop;
	logic [`POOL_FIFO_CNT_W-1:0] in_count;
	logic [`POOL_FIFO_CNT_W-1:0] out_count;
	logic win_valid;
	pool_window_t win_data;
	logic res_valid;
	pool_elem_t res_data;

	// --------------------------------------------------
	// Host pipe FIFOs
	// --------------------------------------------------
	pipe_fifo #(
		.payload_t (pipe_word_t),
		.DEPTH     (`POOL_FIFO_DEPTH)
	) i_in_fifo (
		.okClk   (okClk),
		.arst_n  (arst_n),
		.wr_en   (pi_write),
		.wr_data (pi_data),
		.rd_en   (in_pop),
		.rd_data (in_data),
		.empty   (in_empty),
		.full    (pipe_in_full),
		.count   (in_count)
	);

	pipe_fifo #(
		.payload_t (pool_elem_t),
		.DEPTH     (`POOL_FIFO_DEPTH)
	) i_out_fifo (
		.okClk   (okClk),
		.arst_n  (arst_n),
		.wr_en   (res_valid),
		.wr_data (res_data),
		.rd_en   (po_read),
		.rd_data (po_data),
		.empty   (pipe_out_empty),
		.full    (),  // Never reached, the gatherer holds back
		.count   (out_count)
	);

	block_throttle i_throttle (
		.okClk          (okClk),
		.arst_n         (arst_n),
		.in_count       (in_count),
		.out_count      (out_count),
		.pipe_in_ready  (pipe_in_ready),
		.pipe_out_ready (pipe_out_ready)
	);

	// --------------------------------------------------
	// Pooling path
	// --------------------------------------------------
	window_gather i_gather (
		.okClk     (okClk),
		.arst_n    (arst_n),
		.in_data   (in_data),
		.in_empty  (in_empty),
		.in_pop    (in_pop),
		.out_count (out_count),
		.win_valid (win_valid),
		.win_data  (win_data)
	);

	pool_3x3 i_pool (
		.okClk     (okClk),
		.arst_n    (arst_n),
		.win_valid (win_valid),
		.win_data  (win_data),
		.res_valid (res_valid),
		.res_data  (res_data)
	);

endmodule

// File: pool/pool_3x3.sv
module pool_3x3 (
	input  logic okClk,
	input  logic arst_n,
	input  logic win_valid,
	input  pool_pkg::pool_window_t win_data,
	output logic res_valid,
	output pool_pkg::pool_elem_t res_data
);

	import pool_pkg::*;

	logic [2:0] vld;  // Valid for stages 1 to 3
	pool_elem_t s1 [5];
	pool_elem_t s2 [3];
	pool_elem_t s3 [2];

	// --------------------------------------------------
	// Valid pipeline
	// --------------------------------------------------
	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			vld <= 3'b000;
			res_valid <= 1'b0;
		end else begin
			vld <= {vld[1:0], win_valid};
			res_valid <= vld[2];
		end
	end

	// --------------------------------------------------
	// Comparison tree
	// --------------------------------------------------

	// Stage 1 reduces nine to five
	always_ff @(posedge okClk) begin
		if (win_valid) begin
			for (int i = 0; i < 4; i++) begin
				s1[i] <= elem_max(win_data[2*i], win_data[2*i+1]);
			end
			s1[4] <= win_data[8];  // Odd one passes through
		end
	end

	// Stage 2 reduces five to three
	always_ff @(posedge okClk) begin
		if (vld[0]) begin
			s2[0] <= elem_max(s1[0], s1[1]);
			s2[1] <= elem_max(s1[2], s1[3]);
			s2[2] <= s1[4];
		end
	end

	// Stage 3 reduces three to two
	always_ff @(posedge okClk) begin
		if (vld[1]) begin
			s3[0] <= elem_max(s2[0], s2[1]);
			s3[1] <= s2[2];
		end
	end

	// Final stage
	always_ff @(posedge okClk) begin
		if (vld[2]) begin
			res_data <= elem_max(s3[0], s3[1]);
		end
	end

endmodule

// File: pool/window_gather.sv
`include "pool_cfg.svh"

module window_gather (
	input  logic okClk,
	input  logic arst_n,
	input  pool_pkg::pipe_word_t in_data,
	input  logic in_empty,
	output logic in_pop,
	input  logic [`POOL_FIFO_CNT_W-1:0] out_count,
	output logic win_valid,
	output pool_pkg::pool_window_t win_data
);

	import pool_pkg::*;

	localparam int CNT_W = `POOL_FIFO_CNT_W;
	localparam int LAT = `POOL_LATENCY;

	logic [3:0] idx;           // Next slot in the window
	logic [CNT_W-1:0] inflight;  // Windows not yet in out_count
	logic [LAT-1:0] ret_sr;      // Credit return delay line
	logic [CNT_W:0] occupied;
	logic credit_ok;
	logic win_start;
	logic win_last;

	// Results already stored plus results on their way
	assign occupied = {1'b0, out_count} + {1'b0, inflight};
	assign credit_ok = (occupied < (CNT_W + 1)'(`POOL_FIFO_DEPTH));

	// A new window needs a credit, an unfinished one always proceeds
	assign in_pop = !in_empty && ((idx != 4'd0) || credit_ok);
	assign win_start = in_pop && (idx == 4'd0);
	assign win_last = in_pop && (idx == 4'd8);

	// --------------------------------------------------
	// Window assembly
	// --------------------------------------------------
	always_ff @(posedge okClk) begin
		if (in_pop) begin
			win_data[idx] <= pipe_elem(in_data);
		end
	end

	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			idx <= 4'd0;
			win_valid <= 1'b0;
		end else begin
			win_valid <= win_last;  // Cycle after the ninth pop
			if (win_last) begin
				idx <= 4'd0;
			end else if (in_pop) begin
				idx <= idx + 4'd1;
			end
		end
	end

	// --------------------------------------------------
	// Credits
	// --------------------------------------------------
	// Returned with res_valid, as out_count rises on the same edge
	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			ret_sr <= '0;
			inflight <= '0;
		end else begin
			ret_sr <= {ret_sr[LAT-2:0], win_valid};
			inflight <= inflight + CNT_W'(win_start) - CNT_W'(ret_sr[LAT-1]);
		end
	end

endmodule

// File: verilog/block_throttle.sv
`include "pool_cfg.svh"

module block_throttle (
	input  logic okClk,
	input  logic arst_n,
	input  logic [`POOL_FIFO_CNT_W-1:0] in_count,
	input  logic [`POOL_FIFO_CNT_W-1:0] out_count,
	output logic pipe_in_ready,
	output logic pipe_out_ready
);

	// Room for one more block, less margin for the late count
	localparam int IN_LIMIT = `POOL_FIFO_DEPTH - `POOL_HEADROOM - `POOL_BLOCK_SIZE;

	// A whole block waiting to be read
	localparam int OUT_LIMIT = `POOL_BLOCK_SIZE;

	// --------------------------------------------------
	// Readiness flags
	// --------------------------------------------------
	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			pipe_in_ready <= 1'b0;
			pipe_out_ready <= 1'b0;
		end else begin
			// Input side
			if (int'(in_count) <= IN_LIMIT) begin
				pipe_in_ready <= 1'b1;
			end else begin
				pipe_in_ready <= 1'b0;
			end

			// Output side
			if (int'(out_count) >= OUT_LIMIT) begin
				pipe_out_ready <= 1'b1;
			end else begin
				pipe_out_ready <= 1'b0;
			end
		end
	end

endmodule

// File: verilog/pipe_fifo.sv
`include "pool_cfg.svh"

module pipe_fifo #(
	parameter type payload_t = logic [31:0],
	parameter int DEPTH = `POOL_FIFO_DEPTH
) (
	input  logic okClk,
	input  logic arst_n,
	input  logic wr_en,
	input  payload_t wr_data,
	input  logic rd_en,
	output payload_t rd_data,
	output logic empty,
	output logic full,
	output logic [$clog2(DEPTH+1)-1:0] count
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic do_wr;
	logic do_rd;

	// Wrap at DEPTH, which need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		logic [PTR_W-1:0] nxt;
		if (ptr == PTR_W'(DEPTH - 1)) begin
			nxt = '0;
		end else begin
			nxt = ptr + 1'b1;
		end
		return nxt;
	endfunction

	assign do_wr = wr_en && !full;   // Overflow write dropped
	assign do_rd = rd_en && !empty;  // Underflow read dropped

	assign empty = (count == '0);
	assign full = (count == CNT_W'(DEPTH));

	// Show-ahead head
	assign rd_data = mem[rd_ptr];

	// --------------------------------------------------
	// Storage
	// --------------------------------------------------
	always_ff @(posedge okClk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	// --------------------------------------------------
	// Pointers and fill count
	// --------------------------------------------------
	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (do_rd) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;  // Idle or both at once
			endcase
		end
	end

endmodule

// File: common/pool_pkg.sv
package pool_pkg;

	// Signed 16-bit feature-map element
	typedef logic signed [15:0] pool_elem_t;

	// 32-bit host pipe word with the element in its low half
	typedef logic [31:0] pipe_word_t;

	// 3x3 window in raster order, row 0 first
	typedef pool_elem_t pool_window_t [9];

	// --------------------------------------------------
	// Helpers shared by the gatherer and the core
	// --------------------------------------------------

	// Element carried by a pipe word
	function automatic pool_elem_t pipe_elem(input pipe_word_t word);
		return pool_elem_t'(word[15:0]);  // High half is don't care
	endfunction

	// Signed maximum of two elements
	function automatic pool_elem_t elem_max(
		input pool_elem_t a,
		input pool_elem_t b
	);
		pool_elem_t m;
		if (a > b) begin
			m = a;
		end else begin
			m = b;  // Ties keep b, value is the same
		end
		return m;
	endfunction

endpackage

// File: common/pool_cfg.svh
`ifndef POOL_CFG_SVH
`define POOL_CFG_SVH

// Entries in each pipe FIFO
`define POOL_FIFO_DEPTH 32

// Width of the FIFO fill counts
`define POOL_FIFO_CNT_W 6

// Words per host block
`define POOL_BLOCK_SIZE 4

// Margin for count update latency
`define POOL_HEADROOM 2

// Registered stages in the comparison tree
`define POOL_LATENCY 4

`endif
